/* logic/csr_pkg.sv */
package csr_pkg;

    localparam int TIMER_W = 20;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h0;
    localparam logic [13:0] CSR_PRMD   = 14'h1;
    localparam logic [13:0] CSR_ECFG   = 14'h4;
    localparam logic [13:0] CSR_ESTAT  = 14'h5;
    localparam logic [13:0] CSR_ERA    = 14'h6;
    localparam logic [13:0] CSR_BADV   = 14'h7;
    localparam logic [13:0] CSR_EENTRY = 14'hc;
    localparam logic [13:0] CSR_SAVE0  = 14'h30;
    localparam logic [13:0] CSR_SAVE1  = 14'h31;
    localparam logic [13:0] CSR_SAVE2  = 14'h32;
    localparam logic [13:0] CSR_SAVE3  = 14'h33;
    localparam logic [13:0] CSR_TID    = 14'h40;
    localparam logic [13:0] CSR_TCFG   = 14'h41;
    localparam logic [13:0] CSR_TVAL   = 14'h42;
    localparam logic [13:0] CSR_TICLR  = 14'h44;

    localparam logic [8:0] CRMD_RESET = 9'h8;  // da=1, plv=0, ie=0

    localparam logic [5:0] ECODE_INT = 6'h0;
    localparam logic [5:0] ECODE_ADE = 6'h8;
    localparam logic [5:0] ECODE_ALE = 6'h9;
    localparam logic [5:0] ECODE_SYS = 6'hb;
    localparam logic [5:0] ECODE_BRK = 6'hc;
    localparam logic [5:0] ECODE_INE = 6'hd;

    localparam logic [8:0] ESUB_ADEF = 9'h0;  // fetch address error

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN,
        OP_EXCP
    } csr_op_e;

    typedef struct packed {
        csr_op_e     op;
        logic [13:0] csr_num;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } csr_req_t;

    // staged between issue and commit
    typedef struct packed {
        csr_op_e     op;
        logic [13:0] csr_num;
        logic [31:0] merged;
        logic [31:0] rdata;
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
        logic [31:0] target;  // redirect target, worked out at issue
    } csr_item_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        logic        redirect;
        logic [31:0] target;
    } csr_resp_t;

    typedef struct packed {
        logic [31:0] era;
        logic [31:0] eentry;
        logic        irq;
    } csr_view_t;

    typedef struct packed {
        logic [1:0] plv;
        logic       ie;
    } csr_mode_t;

endpackage

/* logic/csr_timer.sv */
module csr_timer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        tcfg_we,
    input  logic                        ticlr,
    input  logic [csr_pkg::TIMER_W-1:0] wdata,
    output logic [csr_pkg::TIMER_W-1:0] tcfg,
    output logic [csr_pkg::TIMER_W-1:0] tval,
    output logic                        ti
);

    logic reload;

    // tcfg bit 0 enables, bit 1 selects periodic
    assign reload = (tval == '0) && tcfg[1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
            begin
                tcfg <= wdata;
                tval <= {wdata[csr_pkg::TIMER_W-1:2], 2'b00};
            end
            else if (reload)
                tval <= {tcfg[csr_pkg::TIMER_W-1:2], 2'b00};
            else if (tcfg[0] && tval != '0)
                tval <= tval - 1'b1;

            if (ticlr)
                ti <= 1'b0;  // clear has priority
            else if (tval == 1)
                ti <= 1'b1;
        end
    end

    a_tval_no_rise: assert property (
        @(posedge clk) disable iff (!rstn)
        (!tcfg_we && !reload) |=> (tval <= $past(tval))
    );

endmodule

/* logic/csr_issue.sv */
module csr_issue (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_req_t  req,
    input  logic               stall,
    input  logic               flush,
    input  csr_pkg::csr_view_t view,
    output logic [13:0]        rd_num,
    input  logic [31:0]        rd_data,
    output csr_pkg::csr_item_t item,
    output logic               item_valid
);

    logic               req_valid;
    logic               take_int;
    logic               take;
    logic [31:0]        wmask;
    csr_pkg::csr_item_t nxt;

    assign req_valid = req.op != csr_pkg::OP_NONE;
    assign take_int  = req_valid && view.irq;  // beats stall and flush
    assign take      = take_int || (req_valid && !stall && !flush);

    // old value comes back combinationally from the file
    assign rd_num = req.csr_num;
    assign wmask  = (req.op == csr_pkg::OP_CSRWR) ? 32'hffff_ffff : req.mask;

    always_comb
    begin
        nxt.op       = req.op;
        nxt.csr_num  = req.csr_num;
        nxt.merged   = (rd_data & ~wmask) | (req.wdata & wmask);
        nxt.rdata    = 32'h0;
        nxt.pc       = req.pc;
        nxt.ecode    = req.ecode;
        nxt.esubcode = req.esubcode;
        nxt.badv     = req.badv;
        nxt.target   = req.pc + 32'd4;  // csr writes resume after the instruction
        case (req.op)
            csr_pkg::OP_CSRRD,
            csr_pkg::OP_CSRWR,
            csr_pkg::OP_CSRXCHG:
                nxt.rdata = rd_data;
            csr_pkg::OP_ERTN:
                nxt.target = view.era;
            csr_pkg::OP_EXCP:
                nxt.target = view.eentry;
            default:
                nxt.rdata = 32'h0;
        endcase

        // interrupt replaces whatever instruction is presented
        if (take_int)
        begin
            nxt.op       = csr_pkg::OP_EXCP;
            nxt.rdata    = 32'h0;
            nxt.ecode    = csr_pkg::ECODE_INT;
            nxt.esubcode = 9'h0;
            nxt.target   = view.eentry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            item_valid <= 1'b0;
        else
            item_valid <= take;
    end

    always_ff @(posedge clk)
    begin
        if (take)
            item <= nxt;
    end

    // redirect blocks the next acceptance, so no stale read can be staged
    a_no_take_after_redirect: assert property (
        @(posedge clk) disable iff (!rstn)
        (take && nxt.op != csr_pkg::OP_CSRRD) |=> !take
    );

    a_idle_after_reset: assert property (
        @(posedge clk) !rstn |=> !item_valid
    );

endmodule

/* logic/csr_file.sv */
module csr_file (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_item_t item,
    input  logic               item_valid,
    input  logic [13:0]        rd_num,
    output logic [31:0]        rd_data,
    input  logic [7:0]         ext_int,
    output csr_pkg::csr_view_t view,
    output csr_pkg::csr_resp_t resp,
    output csr_pkg::csr_mode_t mode
);

    logic [8:0]                  crmd;
    logic [2:0]                  prmd;
    logic [12:0]                 ecfg_lie;
    logic [1:0]                  is_sw;
    logic [5:0]                  ecode;
    logic [8:0]                  esubcode;
    logic [31:0]                 era;
    logic [31:0]                 badv;
    logic [25:0]                 eentry;
    logic [31:0]                 save [4];
    logic [31:0]                 tid;
    logic [csr_pkg::TIMER_W-1:0] tcfg;
    logic [csr_pkg::TIMER_W-1:0] tval;
    logic                        ti;
    logic [12:0]                 estat_is;
    logic                        csr_we;
    logic                        tcfg_we;
    logic                        ticlr;

    assign csr_we  = item_valid &&
                     (item.op == csr_pkg::OP_CSRWR || item.op == csr_pkg::OP_CSRXCHG);
    assign tcfg_we = csr_we && item.csr_num == csr_pkg::CSR_TCFG;
    assign ticlr   = csr_we && item.csr_num == csr_pkg::CSR_TICLR && item.merged[0];

    csr_timer u_timer (
        .clk     (clk),
        .rstn    (rstn),
        .tcfg_we (tcfg_we),
        .ticlr   (ticlr),
        .wdata   (item.merged[csr_pkg::TIMER_W-1:0]),
        .tcfg    (tcfg),
        .tval    (tval),
        .ti      (ti)
    );

    // no ipi source and bit 10 reserved
    assign estat_is = {1'b0, ti, 1'b0, ext_int, is_sw};

    assign view.era    = era;
    assign view.eentry = {eentry, 6'b0};
    assign view.irq    = crmd[2] && |(estat_is & ecfg_lie);

    assign mode.plv = crmd[1:0];
    assign mode.ie  = crmd[2];

    assign resp.valid    = item_valid;
    assign resp.rdata    = item.rdata;
    assign resp.redirect = item_valid && item.op != csr_pkg::OP_CSRRD;
    assign resp.target   = item.target;

    always_comb
    begin
        case (rd_num)
            csr_pkg::CSR_CRMD:   rd_data = {23'b0, crmd};
            csr_pkg::CSR_PRMD:   rd_data = {29'b0, prmd};
            csr_pkg::CSR_ECFG:   rd_data = {19'b0, ecfg_lie};
            csr_pkg::CSR_ESTAT:  rd_data = {1'b0, esubcode, ecode, 3'b0, estat_is};
            csr_pkg::CSR_ERA:    rd_data = era;
            csr_pkg::CSR_BADV:   rd_data = badv;
            csr_pkg::CSR_EENTRY: rd_data = {eentry, 6'b0};
            csr_pkg::CSR_SAVE0,
            csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3:  rd_data = save[rd_num[1:0]];
            csr_pkg::CSR_TID:    rd_data = tid;
            csr_pkg::CSR_TCFG:   rd_data = {{(32-csr_pkg::TIMER_W){1'b0}}, tcfg};
            csr_pkg::CSR_TVAL:   rd_data = {{(32-csr_pkg::TIMER_W){1'b0}}, tval};
            default:             rd_data = 32'h0;  // ticlr and unused numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd     <= csr_pkg::CRMD_RESET;
            prmd     <= '0;
            ecfg_lie <= '0;
            is_sw    <= '0;
            ecode    <= '0;
            esubcode <= '0;
            era      <= '0;
            badv     <= '0;
            eentry   <= '0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
            tid      <= '0;
        end
        else if (item_valid)
        begin
            case (item.op)
                csr_pkg::OP_EXCP:
                begin
                    prmd      <= crmd[2:0];
                    crmd[2:0] <= 3'b000;
                    era       <= item.pc;
                    ecode     <= item.ecode;
                    esubcode  <= item.esubcode;
                    if (item.ecode != csr_pkg::ECODE_INT)  // interrupts keep badv
                    begin
                        if (item.ecode == csr_pkg::ECODE_ADE &&
                            item.esubcode == csr_pkg::ESUB_ADEF)
                            badv <= item.pc;
                        else
                            badv <= item.badv;
                    end
                end
                csr_pkg::OP_ERTN:
                    crmd[2:0] <= prmd;
                csr_pkg::OP_CSRWR,
                csr_pkg::OP_CSRXCHG:
                begin
                    case (item.csr_num)
                        csr_pkg::CSR_CRMD:   crmd <= item.merged[8:0];
                        csr_pkg::CSR_PRMD:   prmd <= item.merged[2:0];
                        csr_pkg::CSR_ECFG:
                            ecfg_lie <= {item.merged[12:11], 1'b0, item.merged[9:0]};
                        csr_pkg::CSR_ESTAT:  is_sw <= item.merged[1:0];  // sw bits only
                        csr_pkg::CSR_ERA:    era <= item.merged;
                        csr_pkg::CSR_BADV:   badv <= item.merged;
                        csr_pkg::CSR_EENTRY: eentry <= item.merged[31:6];
                        csr_pkg::CSR_SAVE0,
                        csr_pkg::CSR_SAVE1,
                        csr_pkg::CSR_SAVE2,
                        csr_pkg::CSR_SAVE3:  save[item.csr_num[1:0]] <= item.merged;
                        csr_pkg::CSR_TID:    tid <= item.merged;
                        default:             tid <= tid;
                    endcase
                end
                default:
                    crmd <= crmd;
            endcase
        end
    end

endmodule

/* logic/csr_unit.sv */
module csr_unit (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_req_t  req,
    input  logic               stall,
    input  logic               flush,
    input  logic [7:0]         ext_int,
    output csr_pkg::csr_resp_t resp,
    output csr_pkg::csr_mode_t mode
);

    csr_pkg::csr_view_t view;
    csr_pkg::csr_item_t item;
    logic               item_valid;
    logic [13:0]        rd_num;
    logic [31:0]        rd_data;

    csr_issue u_issue (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .flush      (flush),
        .view       (view),
        .rd_num     (rd_num),
        .rd_data    (rd_data),
        .item       (item),
        .item_valid (item_valid)
    );

    // commit stage, one cycle behind issue
    csr_file u_file (
        .clk        (clk),
        .rstn       (rstn),
        .item       (item),
        .item_valid (item_valid),
        .rd_num     (rd_num),
        .rd_data    (rd_data),
        .ext_int    (ext_int),
        .view       (view),
        .resp       (resp),
        .mode       (mode)
    );

endmodule

/* bench/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// what one accepted request should do
typedef struct packed {
    logic             valid;
    csr_pkg::csr_op_e op;
    logic             csr_op;  // rd, wr or xchg, so rdata counts
    logic [13:0]      csr_num;
    logic [31:0]      merged;
    logic [31:0]      rdata;
    logic [31:0]      pc;
    logic [5:0]       ecode;
    logic [8:0]       esubcode;
    logic [31:0]      badv;
    logic [31:0]      target;
} exp_item_t;

logic [8:0]                  m_crmd;
logic [2:0]                  m_prmd;
logic [12:0]                 m_lie;
logic [1:0]                  m_is_sw;
logic [5:0]                  m_ecode;
logic [8:0]                  m_esub;
logic [31:0]                 m_era;
logic [31:0]                 m_badv;
logic [31:0]                 m_eentry;
logic [31:0]                 m_tid;
logic [31:0]                 m_save [4];
logic [csr_pkg::TIMER_W-1:0] m_tcfg;
logic [csr_pkg::TIMER_W-1:0] m_tval;
logic                        m_ti;

task automatic model_reset();
    m_crmd   = csr_pkg::CRMD_RESET;
    m_prmd   = '0;
    m_lie    = '0;
    m_is_sw  = '0;
    m_ecode  = '0;
    m_esub   = '0;
    m_era    = '0;
    m_badv   = '0;
    m_eentry = '0;
    m_tid    = '0;
    m_tcfg   = '0;
    m_tval   = '0;
    m_ti     = 1'b0;
    for (int i = 0; i < 4; i++)
        m_save[i] = '0;
endtask

// is[12] ipi and is[10] never set here
function automatic logic [12:0] model_estat_is(input logic [7:0] ext);
    return {1'b0, m_ti, 1'b0, ext, m_is_sw};
endfunction

function automatic logic [31:0] model_read(input logic [13:0] num, input logic [7:0] ext);
    case (num)
        csr_pkg::CSR_CRMD:   return {23'b0, m_crmd};
        csr_pkg::CSR_PRMD:   return {29'b0, m_prmd};
        csr_pkg::CSR_ECFG:   return {19'b0, m_lie};
        csr_pkg::CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, model_estat_is(ext)};
        csr_pkg::CSR_ERA:    return m_era;
        csr_pkg::CSR_BADV:   return m_badv;
        csr_pkg::CSR_EENTRY: return m_eentry;
        csr_pkg::CSR_SAVE0:  return m_save[0];
        csr_pkg::CSR_SAVE1:  return m_save[1];
        csr_pkg::CSR_SAVE2:  return m_save[2];
        csr_pkg::CSR_SAVE3:  return m_save[3];
        csr_pkg::CSR_TID:    return m_tid;
        csr_pkg::CSR_TCFG:   return {12'b0, m_tcfg};
        csr_pkg::CSR_TVAL:   return {12'b0, m_tval};
        default:             return 32'h0;
    endcase
endfunction

function automatic exp_item_t model_issue(input csr_pkg::csr_req_t r, input logic [7:0] ext,
                                          input logic st, input logic fl);
    exp_item_t   e;
    logic [31:0] old;
    logic [31:0] wm;
    logic        irq;
    irq = m_crmd[2] && ((model_estat_is(ext) & m_lie) != 13'h0);
    old = model_read(r.csr_num, ext);
    wm  = (r.op == csr_pkg::OP_CSRWR) ? 32'hffff_ffff : r.mask;
    e          = '0;
    e.valid    = (r.op != csr_pkg::OP_NONE) && (irq || (!st && !fl));
    e.op       = r.op;
    e.csr_op   = r.op inside {csr_pkg::OP_CSRRD, csr_pkg::OP_CSRWR, csr_pkg::OP_CSRXCHG};
    e.csr_num  = r.csr_num;
    e.merged   = (old & ~wm) | (r.wdata & wm);
    e.rdata    = old;
    e.pc       = r.pc;
    e.ecode    = r.ecode;
    e.esubcode = r.esubcode;
    e.badv     = r.badv;
    e.target   = r.pc + 32'd4;
    if (r.op == csr_pkg::OP_ERTN)
        e.target = m_era;
    if (r.op == csr_pkg::OP_EXCP || irq)
        e.target = m_eentry;
    if (irq)
    begin
        e.op       = csr_pkg::OP_EXCP;
        e.csr_op   = 1'b0;
        e.ecode    = csr_pkg::ECODE_INT;
        e.esubcode = 9'h0;
    end
    return e;
endfunction

// timer step and commit of the staged item for one clock edge
task automatic model_commit(input exp_item_t e);
    logic wr;
    wr = e.valid && (e.op == csr_pkg::OP_CSRWR || e.op == csr_pkg::OP_CSRXCHG);
    if (wr && e.csr_num == csr_pkg::CSR_TICLR && e.merged[0])
        m_ti = 1'b0;
    else if (m_tval == 1)
        m_ti = 1'b1;
    if (m_tval == 0 && m_tcfg[1])
        m_tval = {m_tcfg[csr_pkg::TIMER_W-1:2], 2'b00};
    else if (m_tcfg[0] && m_tval != 0)
        m_tval = m_tval - 1'b1;
    if (e.valid && e.op == csr_pkg::OP_EXCP)
    begin
        m_prmd      = m_crmd[2:0];
        m_crmd[2:0] = 3'b000;
        m_era       = e.pc;
        m_ecode     = e.ecode;
        m_esub      = e.esubcode;
        if (e.ecode != csr_pkg::ECODE_INT)
            m_badv = (e.ecode == csr_pkg::ECODE_ADE && e.esubcode == csr_pkg::ESUB_ADEF) ?
                     e.pc : e.badv;
    end
    if (e.valid && e.op == csr_pkg::OP_ERTN)
        m_crmd[2:0] = m_prmd;
    if (wr)
    begin
        case (e.csr_num)
            csr_pkg::CSR_CRMD:   m_crmd = e.merged[8:0];
            csr_pkg::CSR_PRMD:   m_prmd = e.merged[2:0];
            csr_pkg::CSR_ECFG:   m_lie = e.merged[12:0] & 13'h1bff;
            csr_pkg::CSR_ESTAT:  m_is_sw = e.merged[1:0];
            csr_pkg::CSR_ERA:    m_era = e.merged;
            csr_pkg::CSR_BADV:   m_badv = e.merged;
            csr_pkg::CSR_EENTRY: m_eentry = e.merged & 32'hffff_ffc0;
            csr_pkg::CSR_SAVE0:  m_save[0] = e.merged;
            csr_pkg::CSR_SAVE1:  m_save[1] = e.merged;
            csr_pkg::CSR_SAVE2:  m_save[2] = e.merged;
            csr_pkg::CSR_SAVE3:  m_save[3] = e.merged;
            csr_pkg::CSR_TID:    m_tid = e.merged;
            csr_pkg::CSR_TCFG:
            begin
                m_tcfg = e.merged[csr_pkg::TIMER_W-1:0];
                m_tval = {e.merged[csr_pkg::TIMER_W-1:2], 2'b00};
            end
            default: ;
        endcase
    end
endtask

`endif

/* bench/csr_tb.sv */
module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RANDOM = 300;
    localparam int NUM_EXCP   = 20;
    localparam int NUM_REQS   = NUM_RANDOM + NUM_EXCP * 8 + 80;

    `include "csr_model.svh"

    logic               clk;
    logic               rstn;
    csr_pkg::csr_req_t  req;
    logic               stall;
    logic               flush;
    logic [7:0]         ext_int;
    csr_pkg::csr_resp_t resp;
    csr_pkg::csr_mode_t mode;

    integer      seed;
    int          errors;
    int          tests;
    int          cycles;
    logic        blocked;  // redirect staged, no request allowed this cycle
    exp_item_t   staged;
    logic        seen_valid;
    logic        seen_redirect;
    logic [31:0] seen_rdata;

    logic [13:0] kept [14] = '{
        csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
        csr_pkg::CSR_ERA, csr_pkg::CSR_BADV, csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0,
        csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID,
        csr_pkg::CSR_TCFG, csr_pkg::CSR_TVAL
    };
    logic [5:0] codes [5] = '{
        csr_pkg::ECODE_ADE, csr_pkg::ECODE_ALE, csr_pkg::ECODE_SYS,
        csr_pkg::ECODE_BRK, csr_pkg::ECODE_INE
    };

    csr_unit u_csr_unit (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .stall   (stall),
        .flush   (flush),
        .ext_int (ext_int),
        .resp    (resp),
        .mode    (mode)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        repeat (NUM_REQS * 4 + 2000) @(posedge clk);
        $display("timeout: the tests did not finish in time, the DUT looks hung");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    function automatic csr_pkg::csr_req_t make_req(input csr_pkg::csr_op_e op,
                                                   input logic [13:0] num,
                                                   input logic [31:0] wdata,
                                                   input logic [31:0] mask);
        csr_pkg::csr_req_t r;
        r         = '0;
        r.op      = op;
        r.csr_num = num;
        r.wdata   = wdata;
        r.mask    = mask;
        r.pc      = $random(seed) & 32'hffff_fffc;
        return r;
    endfunction

    // checks the response to the last edge, drives one cycle, steps the model
    task automatic run_cycle(input csr_pkg::csr_req_t r, input logic st, input logic fl);
        exp_item_t e;
        check_value("resp.valid", staged.valid, resp.valid);
        check_value("resp.redirect", staged.valid && staged.op != csr_pkg::OP_CSRRD,
                    resp.redirect);
        if (staged.valid && staged.csr_op)
            check_value("resp.rdata", staged.rdata, resp.rdata);
        if (staged.valid && staged.op != csr_pkg::OP_CSRRD)
            check_value("resp.target", staged.target, resp.target);
        check_value("mode", {29'b0, m_crmd[1:0], m_crmd[2]}, mode);
        req   = r;
        stall = st;
        flush = fl;
        e = model_issue(r, ext_int, st, fl);
        model_commit(staged);
        staged  = e;
        blocked = e.valid && e.op != csr_pkg::OP_CSRRD;
        @(posedge clk);
        #2;
        cycles++;
        seen_valid    = resp.valid;
        seen_redirect = resp.redirect;
        seen_rdata    = resp.rdata;
    endtask

    task automatic send(input csr_pkg::csr_req_t r);
        if (blocked)
            run_cycle('0, 1'b0, 1'b0);
        run_cycle(r, 1'b0, 1'b0);
    endtask

    task automatic end_test(input string name, input int mark);
        repeat (2) run_cycle('0, 1'b0, 1'b0);  // flush out the last response
        tests++;
        $display("test %s: %0d mismatches", name, errors - mark);
    endtask

    task automatic test_reset();
        repeat (2) run_cycle('0, 1'b0, 1'b0);
        foreach (kept[i])
            send(make_req(csr_pkg::OP_CSRRD, kept[i], 32'h0, 32'h0));
    endtask

    task automatic test_random();
        int               k;
        csr_pkg::csr_op_e op;
        logic [13:0]      num;
        repeat (NUM_RANDOM)
        begin
            k  = {$random(seed)} % 3;
            op = (k == 0) ? csr_pkg::OP_CSRRD :
                 (k == 1) ? csr_pkg::OP_CSRWR : csr_pkg::OP_CSRXCHG;
            if ({$random(seed)} % 8 == 0)
                num = 14'h100 + ({$random(seed)} % 64);  // unused range
            else
                num = kept[{$random(seed)} % 14];
            send(make_req(op, num, $random(seed), $random(seed)));
        end
    endtask

    // exception entry, state reads, then ertn back
    task automatic test_exceptions();
        csr_pkg::csr_req_t r;
        logic [2:0]        saved;
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_ECFG, 32'h0, 32'h0));
        repeat (NUM_EXCP)
        begin
            saved = $random(seed);
            send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_CRMD, {28'h0, 1'b1, saved}, 32'h0));
            r          = make_req(csr_pkg::OP_EXCP, 14'h0, 32'h0, 32'h0);
            r.ecode    = codes[{$random(seed)} % 5];
            r.esubcode = (r.ecode == csr_pkg::ECODE_ADE) ? ($random(seed) & 1) : 0;
            r.badv     = $random(seed);
            send(r);
            send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_PRMD, 32'h0, 32'h0));
            send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_ERA, 32'h0, 32'h0));
            send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_ESTAT, 32'h0, 32'h0));
            send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_BADV, 32'h0, 32'h0));
            send(make_req(csr_pkg::OP_ERTN, 14'h0, 32'h0, 32'h0));
            send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_CRMD, 32'h0, 32'h0));
            check_value("mode after ertn", {29'b0, saved[1:0], saved[2]}, mode);
        end
    endtask

    task automatic test_interrupts();
        csr_pkg::csr_req_t r;
        int                initval;
        int                start;
        logic              hit;
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_CRMD, 32'h8, 32'h0));
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_EENTRY, $random(seed), 32'h0));
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_ECFG, 32'h4, 32'h0));  // lie bit 2
        ext_int = 8'h01;
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_CRMD, 32'hc, 32'h0));
        r = make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_SAVE0, 32'h0, 32'h0);
        send(r);
        check_value("interrupt redirect", 1'b1, seen_redirect);
        ext_int = 8'h00;
        send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_ERA, 32'h0, 32'h0));
        check_value("era", r.pc, seen_rdata);

        // one-shot timer
        initval = 2 + {$random(seed)} % 4;
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_ECFG, 32'h800, 32'h0));
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_TCFG, (initval << 2) | 1, 32'h0));
        start = cycles;
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_TICLR, 32'h1, 32'h0));
        send(make_req(csr_pkg::OP_CSRXCHG, csr_pkg::CSR_CRMD, 32'h4, 32'h4));
        hit = 1'b0;
        while (!hit && cycles - start < initval * 4 + 4)
        begin
            send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_TVAL, 32'h0, 32'h0));
            hit = seen_redirect;
        end
        if (!hit)
        begin
            errors++;
            $display("the timer interrupt did not arrive within %0d cycles", initval * 4 + 4);
        end
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_TICLR, 32'h1, 32'h0));
        send(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_ESTAT, 32'h0, 32'h0));
        check_value("estat.is[11]", 1'b0, seen_rdata[11]);
    endtask

    task automatic test_timing();
        csr_pkg::csr_req_t r;
        send(make_req(csr_pkg::OP_CSRWR, csr_pkg::CSR_CRMD, 32'h8, 32'h0));
        run_cycle('0, 1'b0, 1'b0);
        r = make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_SAVE1, 32'h0, 32'h0);
        repeat (3)
        begin
            run_cycle(r, 1'b1, 1'b0);
            check_value("resp.valid under stall", 1'b0, seen_valid);
        end
        run_cycle(r, 1'b0, 1'b0);
        check_value("resp.valid after stall", 1'b1, seen_valid);
        run_cycle(r, 1'b0, 1'b1);
        check_value("resp.valid on flush", 1'b0, seen_valid);
        for (int i = 0; i < 4; i++)
        begin
            run_cycle(make_req(csr_pkg::OP_CSRRD, csr_pkg::CSR_SAVE0 + i, 32'h0, 32'h0),
                      1'b0, 1'b0);
            check_value("resp.valid back to back", 1'b1, seen_valid);
        end
    endtask

    initial
    begin
        int mark;
        seed    = 19;
        errors  = 0;
        tests   = 0;
        cycles  = 0;
        rstn    = 1'b0;
        req     = '0;
        stall   = 1'b0;
        flush   = 1'b0;
        ext_int = 8'h00;
        staged  = '0;
        blocked = 1'b0;
        model_reset();
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;

        mark = errors;
        test_reset();
        end_test("reset values", mark);
        mark = errors;
        test_random();
        end_test("register access", mark);
        mark = errors;
        test_exceptions();
        end_test("exceptions and ertn", mark);
        mark = errors;
        test_interrupts();
        end_test("interrupts", mark);
        mark = errors;
        test_timing();
        end_test("acceptance and timing", mark);

        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+bench
logic/csr_pkg.sv
logic/csr_timer.sv
logic/csr_issue.sv
logic/csr_file.sv
logic/csr_unit.sv
bench/csr_tb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - logic/csr_pkg.sv
  - logic/csr_timer.sv
  - logic/csr_issue.sv
  - logic/csr_file.sv
  - logic/csr_unit.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/csr_tb.sv
